//--- verilog/pipe_stage_pkg.sv
// stage and opcode types; ids are fixed at 6 bits, so no more than 64 instructions can be in flight
`default_nettype none

package pipe_stage_pkg;

    ////////////////////////////////////////
    // id width
    ////////////////////////////////////////

    // ids wrap at DEPTH, which must not exceed 2**ID_W
    parameter int ID_W = 6;

    ////////////////////////////////////////
    // enums
    ////////////////////////////////////////

    // values double as slot index into pipe_occ_t, fetch on top
    typedef enum logic [2:0] {
        st_wb     = 3'd0,
        st_mem    = 3'd1,
        st_ex     = 3'd2,
        st_decode = 3'd3,
        st_fetch  = 3'd4
    } stage_e;

    // instruction class as reported by decode
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_load   = 3'd1,
        op_store  = 3'd2,
        op_branch = 3'd3,
        op_jump   = 3'd4,
        op_system = 3'd5,
        op_nop    = 3'd6
    } opcode_e;

    ////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] id;
    } stage_slot_t;

    // 5 x 7 bits = 35 bits, index with stage_e
    typedef stage_slot_t [4:0] pipe_occ_t;

endpackage

`default_nettype wire

//--- verilog/trace_record_pkg.sv
// trace entry and retire record layouts; cycle fields are 16 bits and wrap
`default_nettype none

package trace_record_pkg;

    ////////////////////////////////////////
    // per-id table entry
    ////////////////////////////////////////

    typedef struct packed {
        logic [31:0]             pc;
        pipe_stage_pkg::opcode_e opcode;
        // cycle number of the first fetch cycle
        logic [15:0]             fetch_cycle;
        // both stall counts stick at 255
        logic [7:0]              fetch_stalls;
        logic [7:0]              decode_stalls;
    } trace_entry_t;

    ////////////////////////////////////////
    // outgoing record
    ////////////////////////////////////////

    typedef struct packed {
        logic [pipe_stage_pkg::ID_W-1:0] id;
        trace_entry_t                    entry;
        // cycle in which retire_valid is high
        logic [15:0]                     retire_cycle;
        // retire_cycle - fetch_cycle - 1, mod 2**16
        logic [15:0]                     latency;
    } retire_rec_t;

    // 6 + 67 + 16 + 16 = 105 bits
    // entry alone is 67 bits

endpackage

`default_nettype wire

//--- verilog/inst_id_tracker.sv
// stall holds fetch and decode only; flush squashes both, and ids skipped by a flush are not reused
`timescale 1ns/1ps
`default_nettype none

module inst_id_tracker #(
    parameter int DEPTH = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      flush,
    output pipe_stage_pkg::pipe_occ_t occ,
    output logic                      d_first,
    output logic [1:0]                squash
);
    import pipe_stage_pkg::*;

    // id handed to the next instruction entering fetch
    logic [ID_W-1:0] next_id;
    logic [ID_W-1:0] next_id_inc;

    // wrap at DEPTH, not at 2**ID_W
    assign next_id_inc = (next_id == ID_W'(DEPTH - 1)) ? '0 : next_id + 1'b1;

    // number of live slots a flush kills this cycle
    assign squash = flush ? (2'(occ[st_fetch].valid) + 2'(occ[st_decode].valid)) : 2'd0;

    ////////////////////////////////////////
    // stage advance
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            occ     <= '0;
            next_id <= '0;
            d_first <= 1'b0;
        end else begin
            // back end never stalls
            occ[st_wb]  <= occ[st_mem];
            occ[st_mem] <= occ[st_ex];

            // bubble into execute on stall, or when decode is squashed
            if (stall || flush) begin
                occ[st_ex] <= '0;
            end else begin
                occ[st_ex] <= occ[st_decode];
            end

            if (!stall) begin
                // new instruction every unstalled cycle
                occ[st_fetch] <= '{valid: 1'b1, id: next_id};
                next_id       <= next_id_inc;
                // old fetch content moves on, unless flushed
                if (flush) begin
                    occ[st_decode] <= '0;
                end else begin
                    occ[st_decode] <= occ[st_fetch];
                end
            end else if (flush) begin
                // stalled flush, front end goes empty
                occ[st_fetch].valid  <= 1'b0;
                occ[st_decode].valid <= 1'b0;
            end

            // high in the first cycle an instruction sits in decode
            d_first <= !stall && !flush && occ[st_fetch].valid;
        end
    end

endmodule

`default_nettype wire

//--- verilog/trace_table.sv
// register-array table, one entry per id; stall counts saturate and cycle fields keep the low 16 bits
`timescale 1ns/1ps
`default_nettype none

module trace_table #(
    parameter int DEPTH   = 64,
    parameter int CYCLE_W = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  pipe_stage_pkg::pipe_occ_t      occ,
    input  logic                           d_first,
    input  logic [31:0]                    fetch_pc,
    input  pipe_stage_pkg::opcode_e        decode_op,
    output logic [CYCLE_W-1:0]             cycle,
    output trace_record_pkg::trace_entry_t wb_entry
);
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    trace_entry_t table_q [DEPTH];

    // fetch slot was loaded with a fresh id at the last edge
    logic        f_load;
    logic        f_first;
    stage_slot_t f_slot;
    stage_slot_t d_slot;
    logic [7:0]  f_stalls_nx;
    logic [7:0]  d_stalls_nx;

    function automatic logic [7:0] sat_inc(input logic [7:0] v);
        logic [7:0] r;
        r = (v == 8'hff) ? v : v + 8'd1;
        return r;
    endfunction

    assign f_slot  = occ[st_fetch];
    assign d_slot  = occ[st_decode];
    assign f_first = f_load && f_slot.valid;

    // first fetch cycle starts the count over, a stall there counts too
    assign f_stalls_nx = f_first ? {7'd0, stall} : sat_inc(table_q[f_slot.id].fetch_stalls);
    assign d_stalls_nx = sat_inc(table_q[d_slot.id].decode_stalls);

    ////////////////////////////////////////
    // cycle counter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle  <= '0;
            f_load <= 1'b0;
        end else begin
            cycle  <= cycle + 1'b1;
            // mirrors the tracker's fetch load rule
            f_load <= !stall;
        end
    end

    ////////////////////////////////////////
    // table writes
    ////////////////////////////////////////

    // fetch and decode never hold the same id, so both ports can write in one cycle
    always_ff @(posedge clk) begin
        if (f_slot.valid && (f_first || stall)) begin
            if (f_first) begin
                table_q[f_slot.id].pc            <= fetch_pc;
                table_q[f_slot.id].fetch_cycle   <= 16'(cycle);
                table_q[f_slot.id].decode_stalls <= 8'd0;
            end
            table_q[f_slot.id].fetch_stalls <= f_stalls_nx;
        end
        if (d_slot.valid) begin
            // opcode is valid on decode_op only in the first decode cycle
            if (d_first) begin
                table_q[d_slot.id].opcode <= decode_op;
            end
            if (stall) begin
                table_q[d_slot.id].decode_stalls <= d_stalls_nx;
            end
        end
    end

    // entry of whatever sits in writeback, read without a register
    assign wb_entry = table_q[occ[st_wb].id];

endmodule

`default_nettype wire

//--- verilog/retire_reporter.sv
// record is a one-cycle strobe with no back-pressure; both counters wrap at 16 bits
`timescale 1ns/1ps
`default_nettype none

module retire_reporter #(
    parameter int CYCLE_W = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  pipe_stage_pkg::pipe_occ_t      occ,
    input  logic [1:0]                     squash,
    input  trace_record_pkg::trace_entry_t wb_entry,
    input  logic [CYCLE_W-1:0]             cycle,
    output logic                           retire_valid,
    output trace_record_pkg::retire_rec_t  retire_rec,
    output logic [15:0]                    retired_count,
    output logic [15:0]                    squashed_count
);
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    stage_slot_t wb_slot;
    // current cycle cut to the record field width
    logic [15:0] now16;

    assign wb_slot = occ[st_wb];
    assign now16   = 16'(cycle);

    ////////////////////////////////////////
    // strobe and counters
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid   <= 1'b0;
            retired_count  <= '0;
            squashed_count <= '0;
        end else begin
            // record goes out the cycle after writeback
            retire_valid   <= wb_slot.valid;
            retired_count  <= retired_count + 16'(wb_slot.valid);
            squashed_count <= squashed_count + 16'(squash);
        end
    end

    ////////////////////////////////////////
    // record payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wb_slot.valid) begin
            retire_rec.id           <= wb_slot.id;
            retire_rec.entry        <= wb_entry;
            // stamped with the cycle of the strobe itself
            retire_rec.retire_cycle <= now16 + 16'd1;
            // (now + 1) - fetch - 1
            retire_rec.latency      <= now16 - wb_entry.fetch_cycle;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pipe_trace_top.sv
// DEPTH must be at most 64 since ids are 6 bits; record cycle fields are the low 16 bits of the counter
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_top #(
    parameter int DEPTH   = 64,
    parameter int CYCLE_W = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [31:0]                   fetch_pc,
    input  pipe_stage_pkg::opcode_e       decode_op,
    output logic                          retire_valid,
    output trace_record_pkg::retire_rec_t retire_rec,
    output logic [15:0]                   retired_count,
    output logic [15:0]                   squashed_count
);
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    ////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////

    pipe_occ_t          occ;
    logic               d_first;
    logic [1:0]         squash;
    logic [CYCLE_W-1:0] cycle;
    trace_entry_t       wb_entry;

    // id and valid through the five stages
    inst_id_tracker #(
        .DEPTH(DEPTH)
    ) u_tracker (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .occ    (occ),
        .d_first(d_first),
        .squash (squash)
    );

    // per-id entry storage and cycle count
    trace_table #(
        .DEPTH  (DEPTH),
        .CYCLE_W(CYCLE_W)
    ) u_table (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .occ      (occ),
        .d_first  (d_first),
        .fetch_pc (fetch_pc),
        .decode_op(decode_op),
        .cycle    (cycle),
        .wb_entry (wb_entry)
    );

    // record out at retire
    retire_reporter #(
        .CYCLE_W(CYCLE_W)
    ) u_reporter (
        .clk           (clk),
        .rst           (rst),
        .occ           (occ),
        .squash        (squash),
        .wb_entry      (wb_entry),
        .cycle         (cycle),
        .retire_valid  (retire_valid),
        .retire_rec    (retire_rec),
        .retired_count (retired_count),
        .squashed_count(squashed_count)
    );

endmodule

`default_nettype wire

//--- tests/pipe_trace_tb.sv
// reference-model testbench for pipe_trace_top; DEPTH fixed at 64, stimulus from a fixed-seed LCG
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_tb;
    import pipe_stage_pkg::*;
    import trace_record_pkg::*;

    localparam int DEPTH      = 64;
    localparam int RST_CYCLES = 10;
    localparam int CYCLES     = 2000;
    // clean tail, drains the pipe and shows back-to-back retirement
    localparam int QUIET      = 20;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    logic [31:0] fetch_pc;
    opcode_e     decode_op;
    logic        retire_valid;
    retire_rec_t retire_rec;
    logic [15:0] retired_count;
    logic [15:0] squashed_count;

    // reference model state
    pipe_occ_t        m_occ;
    logic             m_ffirst;
    logic             m_dfirst;
    logic [5:0]       m_next;
    logic [15:0]      m_cycle;
    trace_entry_t     m_tab [DEPTH];
    int               m_squashed;
    int               m_retired;
    // consecutive cycles with neither stall nor flush
    int               quiet;
    logic             exp_valid;
    retire_rec_t      exp_rec;
    // ids squashed and not yet passed by the retire order walk
    logic [DEPTH-1:0] skip_mark;
    logic [5:0]       next_ret;
    logic [5:0]       walk;
    logic [5:0]       fid;
    logic [5:0]       did;
    logic [5:0]       wid;
    int               errors = 0;
    logic [31:0]      seed;

    pipe_trace_top #(.DEPTH(DEPTH), .CYCLE_W(16)) DUT (.*);

    assign fid = m_occ[st_fetch].id;
    assign did = m_occ[st_decode].id;
    assign wid = m_occ[st_wb].id;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [5:0] id_after(input logic [5:0] v);
        return 6'((int'(v) + 1) % DEPTH);
    endfunction

    // stall counts stick at 255
    function automatic logic [7:0] count_up(input logic [7:0] v);
        return (v == 8'hff) ? v : v + 8'd1;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        errors++;
        $display("ERROR %s: expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
    endtask

    // one clock of stimulus, random_mode low gives a clean cycle
    task automatic drive_cycle(input bit random_mode);
        @(posedge clk);
        seed = lcg_next(seed);
        // roughly 25% stall, 5% flush
        stall <= random_mode && (seed[31:30] == 2'b00);
        flush <= random_mode && (seed[29:24] < 6'd3);
        seed = lcg_next(seed);
        fetch_pc  <= {seed[31:2], 2'b00};
        decode_op <= opcode_e'(seed[18:16] % 3'd7);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            m_occ      <= '0;
            m_ffirst   <= 1'b0;
            m_dfirst   <= 1'b0;
            m_next     <= '0;
            m_cycle    <= '0;
            m_squashed <= 0;
            m_retired  <= 0;
            quiet      <= 0;
            exp_valid  <= 1'b0;
            skip_mark  = '0;
            next_ret   = '0;
        end else begin
            m_cycle <= m_cycle + 16'd1;
            quiet   <= (stall || flush) ? 0 : quiet + 1;

            // fetch data on the first fetch cycle, stall counts on every stall cycle
            if (m_occ[st_fetch].valid && m_ffirst) begin
                m_tab[fid].pc            <= fetch_pc;
                m_tab[fid].fetch_cycle   <= m_cycle;
                m_tab[fid].fetch_stalls  <= {7'd0, stall};
                m_tab[fid].decode_stalls <= 8'd0;
            end else if (m_occ[st_fetch].valid && stall) begin
                m_tab[fid].fetch_stalls <= count_up(m_tab[fid].fetch_stalls);
            end
            if (m_occ[st_decode].valid && m_dfirst) begin
                m_tab[did].opcode <= decode_op;
            end
            if (m_occ[st_decode].valid && stall) begin
                m_tab[did].decode_stalls <= count_up(m_tab[did].decode_stalls);
            end

            // flush kills both front slots, their ids drop out of the retire order
            if (flush) begin
                m_squashed <= m_squashed + int'(m_occ[st_fetch].valid)
                              + int'(m_occ[st_decode].valid);
                if (m_occ[st_fetch].valid)
                    skip_mark[fid] = 1'b1;
                if (m_occ[st_decode].valid)
                    skip_mark[did] = 1'b1;
            end

            // writeback now, record one cycle later
            exp_valid <= m_occ[st_wb].valid;
            if (m_occ[st_wb].valid) begin
                walk = next_ret;
                while (skip_mark[walk]) begin
                    skip_mark[walk] = 1'b0;
                    walk = id_after(walk);
                end
                next_ret = id_after(walk);
                m_retired       <= m_retired + 1;
                exp_rec.id      <= walk;
                exp_rec.entry   <= m_tab[wid];
                exp_rec.latency <= 16'd4 + 16'(m_tab[wid].fetch_stalls)
                                   + 16'(m_tab[wid].decode_stalls);
            end

            // back end always moves; stall or flush puts a bubble into execute
            m_occ[st_wb]  <= m_occ[st_mem];
            m_occ[st_mem] <= m_occ[st_ex];
            m_occ[st_ex]  <= '{valid: m_occ[st_decode].valid && !stall && !flush, id: did};
            if (!stall) begin
                m_occ[st_fetch]  <= '{valid: 1'b1, id: m_next};
                m_occ[st_decode] <= '{valid: m_occ[st_fetch].valid && !flush, id: fid};
                m_next           <= id_after(m_next);
            end else if (flush) begin
                m_occ[st_fetch].valid  <= 1'b0;
                m_occ[st_decode].valid <= 1'b0;
            end
            m_ffirst <= !stall;
            m_dfirst <= !stall && !flush && m_occ[st_fetch].valid;
        end
    end

    ////////////////////////////////////////
    // checks at the falling edge
    ////////////////////////////////////////

    chk_valid: assert property (@(negedge clk) disable iff (rst) retire_valid == exp_valid)
        else report_mismatch("retire_valid", 128'(exp_valid), 128'(retire_valid));
    chk_id: assert property (@(negedge clk) disable iff (rst)
        retire_valid |-> retire_rec.id == exp_rec.id)
        else report_mismatch("retire_id", 128'(exp_rec.id), 128'(retire_rec.id));
    // pc, opcode, fetch cycle and both stall counts in one compare
    chk_entry: assert property (@(negedge clk) disable iff (rst)
        retire_valid |-> retire_rec.entry == exp_rec.entry)
        else report_mismatch("entry", 128'(exp_rec.entry), 128'(retire_rec.entry));
    // retire cycle is the cycle in which the strobe is seen
    chk_timing: assert property (@(negedge clk) disable iff (rst)
        retire_valid |-> {retire_rec.retire_cycle, retire_rec.latency}
                         == {m_cycle, exp_rec.latency})
        else report_mismatch("retire_cycle_latency",
                             128'({m_cycle, exp_rec.latency}),
                             128'({retire_rec.retire_cycle, retire_rec.latency}));
    chk_span: assert property (@(negedge clk) disable iff (rst)
        retire_valid |-> 16'(retire_rec.retire_cycle - retire_rec.entry.fetch_cycle - 16'd1)
                         == retire_rec.latency)
        else report_mismatch("latency_span", 128'(retire_rec.latency),
                             128'(16'(retire_rec.retire_cycle - retire_rec.entry.fetch_cycle
                                      - 16'd1)));
    chk_retired: assert property (@(negedge clk) disable iff (rst)
        retired_count == 16'(m_retired))
        else report_mismatch("retired_count", 128'(16'(m_retired)), 128'(retired_count));
    chk_squashed: assert property (@(negedge clk) disable iff (rst)
        squashed_count == 16'(m_squashed))
        else report_mismatch("squashed_count", 128'(16'(m_squashed)), 128'(squashed_count));
    // first five cycles out of reset stay silent, counters read zero right after reset
    chk_reset: assert property (@(negedge clk) disable iff (rst)
        m_cycle < 16'd5 |-> !retire_valid
                            && (m_cycle != 16'd0 || {retired_count, squashed_count} == 32'd0))
        else report_mismatch("post_reset", 128'd0,
                             128'({retire_valid, retired_count, squashed_count}));
    chk_quiet: assert property (@(negedge clk) disable iff (rst) quiet >= 10 |-> retire_valid)
        else report_mismatch("back_to_back", 128'd1, 128'(retire_valid));

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////

    initial begin
        seed      = 32'hba26;
        rst       = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        fetch_pc  = '0;
        decode_op = op_nop;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (CYCLES) drive_cycle(1'b1);
        repeat (QUIET) drive_cycle(1'b0);
        @(negedge clk);
        $display("errors %0d, retired %0d, squashed %0d", errors, m_retired, m_squashed);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog, whole run plus 50 cycles of margin
    initial begin
        #((RST_CYCLES + CYCLES + QUIET + 50) * 4);
        $display("timeout: the run did not reach its end in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/pipe_stage_pkg.sv
verilog/trace_record_pkg.sv
verilog/inst_id_tracker.sv
verilog/trace_table.sv
verilog/retire_reporter.sv
verilog/pipe_trace_top.sv
tests/pipe_trace_tb.sv

//--- Makefile
# Verilator build and run; any variable can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= pipe_trace_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
